//--- design/tti_pkg.sv
// Byte-path types for the RX side; QueueDepth has to stay a power of two
package tti_pkg;

  // RX byte queue
  localparam int unsigned QueueDepth = 16;
  localparam int unsigned QueueCntW = $clog2(QueueDepth + 1);

  // One beat of a bus write, last marks its final byte
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } tti_byte_t;

  // Single-cycle bus events, addr holds the 7-bit address and RnW in bit 0
  typedef struct packed {
    logic       start;
    logic       addr_valid;
    logic [7:0] addr;
  } bus_event_t;

endpackage

//--- design/recovery_pkg.sv
// Recovery protocol constants and types; covers write commands only, read commands are not described
package recovery_pkg;

  // Device status value that enables recovery mode
  localparam logic [7:0] RecModeValue = 8'h03;

  // Write command codes
  localparam logic [7:0] CmdRecoveryCtrl = 8'h26;
  localparam logic [7:0] CmdIndirectData = 8'h2B;

  localparam logic [15:0] RecCtrlLen = 16'd3;
  localparam logic [7:0] ActivateImage = 8'h0F;

  // CRC-8, zero initial value, MSB first
  localparam logic [7:0] PecPoly = 8'h07;

  // Recovery control payload, byte 0 is the first on the bus
  typedef struct packed {
    logic [7:0] cms;
    logic [7:0] image_sel;
    logic [7:0] activate;
  } rec_ctrl_fields_t;

  typedef union packed {
    logic [0:2][7:0]  bytes;
    rec_ctrl_fields_t fields;
  } rec_ctrl_u;

  typedef struct packed {
    logic [7:0] cmd;
    rec_ctrl_u  ctrl;
    logic       error;
  } rec_cmd_t;

  typedef struct packed {
    logic       payload_available;
    logic       image_activated;
    logic [7:0] err_count;
  } rec_status_t;

endpackage

//--- design/tti_rx_queue.sv
// Show-ahead byte FIFO; QueueDepth must be a power of two and the last flag is not stored
`timescale 1ns/10ps

module tti_rx_queue
  import tti_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  tti_byte_t            wr_i,
  input  logic                 wr_valid_i,
  output logic                 wr_ready_o,

  input  logic                 route_rec_i,
  input  tti_byte_t            fwd_i,
  input  logic                 fwd_valid_i,
  output logic                 fwd_ready_o,

  input  logic                 clr_i,

  output tti_byte_t            rd_o,
  output logic                 rd_valid_o,
  input  logic                 rd_ready_i,

  output logic                 empty_o,
  output logic                 full_o,
  output logic [QueueCntW-1:0] depth_o
);

  logic [7:0] mem_q [QueueDepth];
  logic [$clog2(QueueDepth)-1:0] wr_ptr_q;
  logic [$clog2(QueueDepth)-1:0] rd_ptr_q;
  logic [QueueCntW-1:0] cnt_q;
  logic push;
  logic pop;
  logic [7:0] push_data;

  assign full_o  = cnt_q == QueueCntW'(QueueDepth);
  assign empty_o = cnt_q == '0;
  assign depth_o = cnt_q;

  // Only one write port is open at a time
  assign wr_ready_o  = ~full_o & ~route_rec_i;
  assign fwd_ready_o = ~full_o & route_rec_i;

  assign push      = route_rec_i ? (fwd_valid_i & fwd_ready_o) : (wr_valid_i & wr_ready_o);
  assign push_data = route_rec_i ? fwd_i.data : wr_i.data;
  assign pop       = rd_ready_i & ~empty_o;

  assign rd_o       = '{data: mem_q[rd_ptr_q], last: 1'b0};
  assign rd_valid_o = ~empty_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q <= cnt_q + QueueCntW'(push) - QueueCntW'(pop);
    end
  end

endmodule

//--- design/recovery_mux.sv
// Combinational stream steering; a mode change in the middle of a packet is not guarded against
`timescale 1ns/10ps

module recovery_mux
  import tti_pkg::*;
  import recovery_pkg::*;
(
  input  logic       [7:0] dev_status_i,

  // Incoming bus stream
  input  tti_byte_t        rx_i,
  input  logic             rx_valid_i,
  output logic             rx_ready_o,

  // Queue direct port
  output logic             q_valid_o,
  input  logic             q_ready_i,

  // Recovery receiver
  output logic             rcv_valid_o,
  input  logic             rcv_ready_i,

  output logic             rec_mode_o
);

  assign rec_mode_o = dev_status_i == RecModeValue;

  // Data goes to both sinks, only valid is steered
  always_comb begin
    if (rec_mode_o) begin
      q_valid_o   = 1'b0;
      rcv_valid_o = rx_valid_i;
      rx_ready_o  = rcv_ready_i;
    end else begin
      q_valid_o   = rx_valid_i;
      rcv_valid_o = 1'b0;
      rx_ready_o  = q_ready_i;
    end
  end

endmodule

//--- design/recovery_pec.sv
// Bytewise CRC-8 accumulator, zero seed and no final XOR; a clear and a byte in one cycle start afresh
`timescale 1ns/10ps

module recovery_pec
  import recovery_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       valid_i,
  input  logic [7:0] data_i,
  output logic [7:0] crc_o
);

  logic [7:0] crc_q;
  logic [7:0] base;

  function automatic logic [7:0] crc8_byte(logic [7:0] crc, logic [7:0] data);
    logic [7:0] c;
    c = crc ^ data;
    for (int i = 0; i < 8; i++) begin
      c = c[7] ? ((c << 1) ^ PecPoly) : (c << 1);
    end
    return c;
  endfunction

  assign base = clear_i ? 8'h00 : crc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc_q <= '0;
    end else if (clear_i || valid_i) begin
      crc_q <= valid_i ? crc8_byte(base, data_i) : 8'h00;
    end
  end

  assign crc_o = crc_q;

endmodule

//--- design/recovery_receiver.sv
// Parses write packets only; read addresses are ignored and bytes outside a packet are dropped
`timescale 1ns/10ps

module recovery_receiver
  import tti_pkg::*;
  import recovery_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       rec_mode_i,
  input  bus_event_t bus_i,

  input  tti_byte_t  rx_i,
  input  logic       rx_valid_i,
  output logic       rx_ready_o,

  output tti_byte_t  fwd_o,
  output logic       fwd_valid_o,
  input  logic       fwd_ready_i,
  output logic       route_rec_o,
  output logic       q_clr_o,

  output rec_cmd_t   cmd_o,
  output logic       cmd_valid_o
);

  typedef enum logic [2:0] {Idle, Cmd, LenLo, LenHi, Payload, Pec, Skip} rx_state_e;

  rx_state_e state_q, state_d;
  logic [7:0] cmd_q;
  logic [7:0] len_lo_q;
  logic [15:0] rem_q, rem_d;
  rec_ctrl_u ctrl_q;
  logic route_q, route_d;
  logic cmd_valid_q;
  logic cmd_err_q;
  logic accept, bus_wr, is_ind, end_err;
  logic pec_clear, pec_valid;
  logic [7:0] pec_data, pec_crc;

  assign bus_wr = bus_i.addr_valid & ~bus_i.addr[0];
  assign is_ind = cmd_q == CmdIndirectData;

  // Indirect payload is stalled by a full queue
  assign rx_ready_o = (state_q == Payload && is_ind) ? fwd_ready_i : 1'b1;
  assign accept     = rx_valid_i & rx_ready_o;

  assign fwd_o       = rx_i;
  assign fwd_valid_o = rx_valid_i & (state_q == Payload) & is_ind;

  // Address seeds the PEC, the PEC byte itself is not folded in
  assign pec_clear = ~rec_mode_i | bus_i.start | bus_wr;
  assign pec_valid = bus_wr | (accept & (state_q inside {Cmd, LenLo, LenHi, Payload}));
  assign pec_data  = bus_wr ? bus_i.addr : rx_i.data;

  recovery_pec recovery_pec_i (
    .clk_i,
    .rst_ni,
    .clear_i(pec_clear),
    .valid_i(pec_valid),
    .data_i (pec_data),
    .crc_o  (pec_crc)
  );

  // Packet is good only if its last byte is the PEC and it matches
  assign end_err = (state_q != Pec) | (rx_i.data != pec_crc);

  always_comb begin
    state_d = state_q;
    rem_d   = rem_q;
    if (accept) begin
      unique case (state_q)
        Cmd: begin
          if (rx_i.data == CmdRecoveryCtrl || rx_i.data == CmdIndirectData) state_d = LenLo;
          else state_d = Skip;
        end
        LenLo: state_d = LenHi;
        LenHi: begin
          rem_d = {rx_i.data, len_lo_q};
          if (cmd_q == CmdRecoveryCtrl && rem_d != RecCtrlLen) state_d = Skip;
          else if (rem_d == '0) state_d = Pec;
          else state_d = Payload;
        end
        Payload: begin
          rem_d = rem_q - 16'd1;
          if (rem_d == '0) state_d = Pec;
        end
        // PEC without last flag means the packet runs long
        Pec: state_d = Skip;
        default: ;
      endcase
      if (rx_i.last && state_q != Idle) state_d = Idle;
    end
    if (bus_wr) state_d = Cmd;
    else if (bus_i.start) state_d = Idle;
  end

  assign route_d = is_ind & (state_d == Payload || state_d == Pec);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      route_q     <= 1'b0;
      cmd_valid_q <= 1'b0;
    end else if (!rec_mode_i) begin
      state_q     <= Idle;
      route_q     <= 1'b0;
      cmd_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      route_q     <= route_d;
      cmd_valid_q <= accept & rx_i.last & (state_q != Idle);
    end
  end

  always_ff @(posedge clk_i) begin
    rem_q <= rem_d;
    if (accept) begin
      if (state_q == Cmd) cmd_q <= rx_i.data;
      if (state_q == LenLo) len_lo_q <= rx_i.data;
      if (state_q == Payload && !is_ind) ctrl_q.bytes[2'(RecCtrlLen - rem_q)] <= rx_i.data;
      if (rx_i.last) cmd_err_q <= end_err;
    end
  end

  assign route_rec_o = route_q;
  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = '{cmd: cmd_q, ctrl: ctrl_q, error: cmd_err_q};

  // Failed indirect write drops what it already queued
  assign q_clr_o = cmd_valid_q & cmd_err_q & is_ind;

endmodule

//--- design/recovery_executor.sv
// All status clears when recovery mode is left; the error count saturates at 255
`timescale 1ns/10ps

module recovery_executor
  import recovery_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        rec_mode_i,
  input  rec_cmd_t    cmd_i,
  input  logic        cmd_valid_i,
  input  logic        q_empty_i,
  output rec_status_t status_o
);

  logic       pending_q;
  logic       image_q;
  logic [7:0] err_cnt_q;
  logic       cmd_good;
  logic       cmd_bad;
  logic       activate;
  logic       ind_done;

  assign cmd_good = cmd_valid_i & ~cmd_i.error;
  assign cmd_bad  = cmd_valid_i & cmd_i.error;

  assign activate = cmd_good & (cmd_i.cmd == CmdRecoveryCtrl) &
                    (cmd_i.ctrl.fields.activate == ActivateImage);
  assign ind_done = cmd_good & (cmd_i.cmd == CmdIndirectData);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      image_q   <= 1'b0;
      err_cnt_q <= '0;
    end else if (!rec_mode_i) begin
      pending_q <= 1'b0;
      image_q   <= 1'b0;
      err_cnt_q <= '0;
    end else begin
      if (cmd_bad && err_cnt_q != 8'hFF) begin
        err_cnt_q <= err_cnt_q + 8'd1;
      end
      if (activate) begin
        image_q <= 1'b1;
      end
      // Firmware has read the image data once the queue runs dry
      if (ind_done) begin
        pending_q <= 1'b1;
      end else if (q_empty_i) begin
        pending_q <= 1'b0;
      end
    end
  end

  assign status_o = '{
    payload_available: pending_q & ~q_empty_i,
    image_activated:   image_q,
    err_count:         err_cnt_q
  };

endmodule

//--- design/recovery_handler.sv
// Recovery front end without TX path or interrupt; an errored indirect write flushes the whole RX queue
`timescale 1ns/10ps

module recovery_handler
  import tti_pkg::*;
  import recovery_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [7:0]  dev_status_i,
  input  bus_event_t  bus_i,

  input  tti_byte_t   rx_i,
  input  logic        rx_valid_i,
  output logic        rx_ready_o,

  output tti_byte_t   csr_rd_o,
  output logic        csr_rd_valid_o,
  input  logic        csr_rd_ready_i,

  output rec_status_t status_o
);

  logic      rec_mode;
  logic      q_valid, q_ready;
  logic      rcv_valid, rcv_ready;
  tti_byte_t fwd;
  logic      fwd_valid, fwd_ready;
  logic      route_rec;
  logic      q_clr;
  logic      q_empty;
  rec_cmd_t  cmd;
  logic      cmd_valid;

  recovery_mux recovery_mux_i (
    .dev_status_i,
    .rx_i,
    .rx_valid_i,
    .rx_ready_o,
    .q_valid_o  (q_valid),
    .q_ready_i  (q_ready),
    .rcv_valid_o(rcv_valid),
    .rcv_ready_i(rcv_ready),
    .rec_mode_o (rec_mode)
  );

  tti_rx_queue tti_rx_queue_i (
    .clk_i,
    .rst_ni,
    .wr_i       (rx_i),
    .wr_valid_i (q_valid),
    .wr_ready_o (q_ready),
    .route_rec_i(route_rec),
    .fwd_i      (fwd),
    .fwd_valid_i(fwd_valid),
    .fwd_ready_o(fwd_ready),
    .clr_i      (q_clr),
    .rd_o       (csr_rd_o),
    .rd_valid_o (csr_rd_valid_o),
    .rd_ready_i (csr_rd_ready_i),
    .empty_o    (q_empty),
    .full_o     (),
    .depth_o    ()
  );

  recovery_receiver recovery_receiver_i (
    .clk_i,
    .rst_ni,
    .rec_mode_i (rec_mode),
    .bus_i,
    .rx_i,
    .rx_valid_i (rcv_valid),
    .rx_ready_o (rcv_ready),
    .fwd_o      (fwd),
    .fwd_valid_o(fwd_valid),
    .fwd_ready_i(fwd_ready),
    .route_rec_o(route_rec),
    .q_clr_o    (q_clr),
    .cmd_o      (cmd),
    .cmd_valid_o(cmd_valid)
  );

  recovery_executor recovery_executor_i (
    .clk_i,
    .rst_ni,
    .rec_mode_i (rec_mode),
    .cmd_i      (cmd),
    .cmd_valid_i(cmd_valid),
    .q_empty_i  (q_empty),
    .status_o
  );

endmodule

//--- bench/recovery_handler_assertions.sv
// Bound to recovery_handler; the error count rule only holds while recovery mode stays on
`timescale 1ns/10ps

module recovery_handler_assertions
  import tti_pkg::*;
  import recovery_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input tti_byte_t   rx_i,
  input logic        rx_valid_i,
  input logic        rx_ready_i,
  input tti_byte_t   csr_rd_i,
  input logic        csr_rd_valid_i,
  input logic        csr_rd_ready_i,
  input logic        q_clr_i,
  input logic        rec_mode_i,
  input rec_status_t status_i
);

  int unsigned fail_cnt = 0;

  rx_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_valid_i && !rx_ready_i |=> rx_valid_i && $stable(rx_i))
    else begin
      fail_cnt++;
      $error("rx_i dropped or changed before its transfer");
    end

  // A queue clear may withdraw the head byte
  csr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_rd_valid_i && !csr_rd_ready_i && !q_clr_i |=> csr_rd_valid_i && $stable(csr_rd_i))
    else begin
      fail_cnt++;
      $error("csr_rd_o dropped or changed before its transfer");
    end

  // An empty queue only fills from a bus beat taken on the edge before
  csr_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(csr_rd_valid_i) |-> $past(rx_valid_i && rx_ready_i))
    else begin
      fail_cnt++;
      $error("csr_rd_valid_o rose without a byte written into the empty queue");
    end

  err_count_up: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rec_mode_i |=> status_i.err_count >= $past(status_i.err_count))
    else begin
      fail_cnt++;
      $error("Error count went down in recovery mode");
    end

endmodule

bind recovery_handler recovery_handler_assertions recovery_handler_assertions_i (
  .clk_i,
  .rst_ni,
  .rx_i,
  .rx_valid_i,
  .rx_ready_i    (rx_ready_o),
  .csr_rd_i      (csr_rd_o),
  .csr_rd_valid_i(csr_rd_valid_o),
  .csr_rd_ready_i,
  .q_clr_i       (q_clr),
  .rec_mode_i    (rec_mode),
  .status_i      (status_o)
);

//--- bench/recovery_handler_tb.sv
// Packets go to one fixed target address and never carry more than the 16 bytes the queue holds
`timescale 1ns/10ps

module recovery_handler_tb
  import tti_pkg::*;
  import recovery_pkg::*;
();

  localparam int unsigned Timeout = 200;
  localparam logic [7:0] TgtAddr = 8'hB4;

  logic        clk_i;
  logic        rst_ni;
  logic [7:0]  dev_status_i;
  bus_event_t  bus_i;
  tti_byte_t   rx_i;
  logic        rx_valid_i;
  logic        rx_ready_o;
  tti_byte_t   csr_rd_o;
  logic        csr_rd_valid_o;
  logic        csr_rd_ready_i;
  rec_status_t status_o;

  // Model state
  logic [7:0]  exp_q[$];
  logic [7:0]  pkt_q[$];
  rec_status_t exp_status;
  int unsigned err_cnt;
  int unsigned timeout_cnt;
  int unsigned checks;

  recovery_handler recovery_handler_i (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // Bit-serial CRC-8, MSB first
  function automatic logic [7:0] crc8_update(logic [7:0] crc, logic [7:0] data);
    logic fb;
    for (int i = 7; i >= 0; i--) begin
      fb  = crc[7] ^ data[i];
      crc = {crc[6:0], 1'b0} ^ (fb ? PecPoly : 8'h00);
    end
    return crc;
  endfunction

  task automatic check_value(string name, logic [15:0] got, logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  task automatic note_timeout(string what);
    timeout_cnt++;
    $display("Timed out waiting for %s at %0t", what, $time);
  endtask

  // Returns with the beat taken at the coming edge
  task automatic send_byte(logic [7:0] data, logic last);
    int waited;
    waited = 0;
    @(posedge clk_i);
    #2;
    rx_i       = '{data: data, last: last};
    rx_valid_i = 1'b1;
    #1;
    while (!rx_ready_o && waited < Timeout) begin
      waited++;
      @(posedge clk_i);
      #3;
    end
    if (!rx_ready_o) note_timeout("rx_ready_o");
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(posedge clk_i);
      #2;
      rx_valid_i = 1'b0;
    end
  endtask

  task automatic send_stream(int n);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      b = 8'($urandom);
      if ($urandom_range(3) == 0) idle_cycles(1 + $urandom_range(2));
      send_byte(b, i == n - 1);
      exp_q.push_back(b);
    end
    idle_cycles(1);
  endtask

  task automatic drain_bytes(int n, int ready_pct);
    int waited;
    tti_byte_t exp_beat;
    for (int i = 0; i < n; i++) begin
      waited = 0;
      do begin
        @(posedge clk_i);
        #2;
        csr_rd_ready_i = $urandom_range(99) < ready_pct;
        #1;
        waited++;
      end while (!(csr_rd_valid_o && csr_rd_ready_i) && waited < Timeout);
      if (!(csr_rd_valid_o && csr_rd_ready_i)) begin
        note_timeout("csr_rd_valid_o");
        break;
      end
      assert (exp_q.size() != 0) else begin
        $display("Byte at csr_rd_o with no byte expected at %0t", $time);
        err_cnt++;
      end
      // The read side never carries a last flag
      if (exp_q.size() != 0) begin
        exp_beat = '{data: exp_q.pop_front(), last: 1'b0};
        check_value("csr_rd_o", 16'(csr_rd_o), 16'(exp_beat));
      end
    end
    @(posedge clk_i);
    #2;
    csr_rd_ready_i = 1'b0;
    #1;
  endtask

  // START, write address, then command, length, payload and PEC
  task automatic send_packet(logic [7:0] cmd, int len_delta, bit bad_pec);
    logic [7:0]  pec;
    logic [15:0] len;
    len = 16'(pkt_q.size() + len_delta);
    @(posedge clk_i);
    #2;
    bus_i = '{start: 1'b1, addr_valid: 1'b0, addr: 8'h00};
    @(posedge clk_i);
    #2;
    bus_i = '{start: 1'b0, addr_valid: 1'b1, addr: TgtAddr};
    @(posedge clk_i);
    #2;
    bus_i = '0;
    pec = crc8_update(8'h00, TgtAddr);
    send_byte(cmd, 1'b0);
    pec = crc8_update(pec, cmd);
    send_byte(len[7:0], 1'b0);
    pec = crc8_update(pec, len[7:0]);
    send_byte(len[15:8], 1'b0);
    pec = crc8_update(pec, len[15:8]);
    foreach (pkt_q[i]) begin
      send_byte(pkt_q[i], 1'b0);
      pec = crc8_update(pec, pkt_q[i]);
    end
    send_byte(bad_pec ? ~pec : pec, 1'b1);
    // Status follows two edges after the PEC byte
    @(posedge clk_i);
    #2;
    rx_valid_i = 1'b0;
    @(posedge clk_i);
    #3;
  endtask

  // Kinds: 0/1 good, 2/3 bad PEC, 4/5 bad length; odd kinds are indirect data
  task automatic run_packet(int kind);
    bit is_ind;
    bit bad_pec;
    int delta;
    int n;
    is_ind  = kind % 2 == 1;
    bad_pec = kind == 2 || kind == 3;
    delta   = kind >= 4 ? ($urandom_range(1) ? 1 : -1) : 0;
    n       = is_ind ? 1 + $urandom_range(QueueDepth - 2) : 3;
    pkt_q.delete();
    repeat (n) pkt_q.push_back(8'($urandom));
    if (!is_ind && $urandom_range(1) == 1) pkt_q[2] = ActivateImage;
    if (kind <= 1) begin
      if (!is_ind && pkt_q[2] == ActivateImage) exp_status.image_activated = 1'b1;
      if (is_ind) begin
        exp_status.payload_available = 1'b1;
        foreach (pkt_q[i]) exp_q.push_back(pkt_q[i]);
      end
    end else if (exp_status.err_count != 8'hFF) begin
      exp_status.err_count = exp_status.err_count + 8'd1;
    end
    send_packet(is_ind ? CmdIndirectData : CmdRecoveryCtrl, delta, bad_pec);
    check_value("status_o", 16'(status_o), 16'(exp_status));
    check_value("csr_rd_valid_o", 16'(csr_rd_valid_o), 16'(exp_q.size() != 0));
    if (exp_q.size() != 0) begin
      drain_bytes(exp_q.size(), 60);
      exp_status.payload_available = 1'b0;
      check_value("status_o", 16'(status_o), 16'(exp_status));
      check_value("csr_rd_valid_o", 16'(csr_rd_valid_o), 16'h0);
    end
  endtask

  initial begin
    void'($urandom(32'h3611e47d));
    err_cnt        = 0;
    timeout_cnt    = 0;
    checks         = 0;
    exp_status     = '0;
    rst_ni         = 1'b0;
    dev_status_i   = 8'h00;
    bus_i          = '0;
    rx_i           = '0;
    rx_valid_i     = 1'b0;
    csr_rd_ready_i = 1'b0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    #1;
    check_value("csr_rd_valid_o", 16'(csr_rd_valid_o), 16'h0);
    check_value("status_o", 16'(status_o), 16'h0);
    check_value("rx_ready_o", 16'(rx_ready_o), 16'h1);

    // Normal mode pass-through under back-pressure
    fork
      send_stream(48);
      drain_bytes(48, 50);
    join
    @(posedge clk_i);
    #3;
    check_value("csr_rd_valid_o", 16'(csr_rd_valid_o), 16'h0);
    check_value("leftover bytes", 16'(exp_q.size()), 16'h0);

    @(posedge clk_i);
    #2;
    dev_status_i = RecModeValue;
    repeat (30) run_packet($urandom_range(5));

    $display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d", checks, err_cnt,
             timeout_cnt, recovery_handler_i.recovery_handler_assertions_i.fail_cnt);
    if (err_cnt == 0 && timeout_cnt == 0 &&
        recovery_handler_i.recovery_handler_assertions_i.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- src.f
design/tti_pkg.sv
design/recovery_pkg.sv
design/tti_rx_queue.sv
design/recovery_mux.sv
design/recovery_pec.sv
design/recovery_receiver.sv
design/recovery_executor.sv
design/recovery_handler.sv
bench/recovery_handler_assertions.sv
bench/recovery_handler_tb.sv
